// File: verilog/chip8_pkg.sv
// Shared widths, enums and constants of the CHIP-8 execute core
`default_nettype none

package chip8_pkg;

	// One instruction word
	typedef logic [15:0] opcode_t;

	// Contents of a V register or of the delay timer
	typedef logic [7:0] byte_t;

	// V register number, V0 to VF
	typedef logic [3:0] reg_idx_t;

	// Program address, 4 KiB space
	typedef logic [11:0] addr_t;

	// ALU functions used by 6xkk, 7xkk and the 8xyk group
	typedef enum logic [3:0] {
		PASS_B,
		OR,
		AND,
		XOR,
		ADD,
		SUB,
		SUBN,
		SHR,
		SHL
	} alu_op_t;

	// Skip tests for 3xkk, 4xkk, 5xy0 and 9xy0
	typedef enum logic [1:0] {
		NONE,
		EQ,
		NE
	} skip_t;

	// Sources of the next program counter
	typedef enum logic [1:0] {
		NEXT,
		SKIP,
		JUMP,
		JUMP_V0
	} pc_sel_t;

	// Per-instruction sequence
	typedef enum logic [1:0] {
		IDLE,
		READ,
		EXEC
	} exec_state_t;

	// Programs are loaded at 0x200
	localparam addr_t PROGRAM_START = 12'h200;
	// VF carries the carry, borrow and shift flags
	localparam reg_idx_t FLAG_REG = 4'hF;
	// Every opcode is two bytes
	localparam addr_t INSTR_BYTES = 12'd2;

endpackage

`default_nettype wire

// File: verilog/chip8_decoder.sv
// Opcode decoder producing ALU, writeback, timer and PC controls
`timescale 1ns/1ps
`default_nettype none

module chip8_decoder import chip8_pkg::*; (
	input  opcode_t  op,
	output reg_idx_t rd_a,
	output reg_idx_t rd_b,
	output alu_op_t  alu_op,
	output logic     use_imm,
	output byte_t    imm,
	output skip_t    skip,
	output pc_sel_t  pc_sel,
	output addr_t    target,
	output logic     wb_en,
	output logic     wb_src_timer,
	output logic     vf_en,
	output logic     dt_we,
	output logic     unsupported
);

	always_comb begin
		// Fields sit at fixed positions, so take them straight from the opcode
		rd_a         = op[11:8];
		rd_b         = op[7:4];
		imm          = op[7:0];
		target       = op[11:0];
		alu_op       = PASS_B;
		use_imm      = 1'b0;
		skip         = NONE;
		pc_sel       = NEXT;
		wb_en        = 1'b0;
		wb_src_timer = 1'b0;
		vf_en        = 1'b0;
		dt_we        = 1'b0;
		unsupported  = 1'b0;

		case (op[15:12])
			4'h1: pc_sel = JUMP;
			4'h3: begin
				// Vx against kk
				skip    = EQ;
				use_imm = 1'b1;
				pc_sel  = SKIP;
			end
			4'h4: begin
				skip    = NE;
				use_imm = 1'b1;
				pc_sel  = SKIP;
			end
			4'h5: begin
				// Only 5xy0 is defined
				if (op[3:0] == 4'h0) begin
					skip   = EQ;
					pc_sel = SKIP;
				end else begin
					unsupported = 1'b1;
				end
			end
			4'h6: begin
				use_imm = 1'b1;
				wb_en   = 1'b1;
			end
			4'h7: begin
				// Add byte leaves VF alone
				alu_op  = ADD;
				use_imm = 1'b1;
				wb_en   = 1'b1;
			end
			4'h8: begin
				wb_en = 1'b1;
				case (op[3:0])
					4'h0: alu_op = PASS_B;
					4'h1: alu_op = OR;
					4'h2: alu_op = AND;
					4'h3: alu_op = XOR;
					4'h4: begin
						alu_op = ADD;
						vf_en  = 1'b1;
					end
					4'h5: begin
						alu_op = SUB;
						vf_en  = 1'b1;
					end
					4'h6: begin
						alu_op = SHR;
						vf_en  = 1'b1;
					end
					4'h7: begin
						alu_op = SUBN;
						vf_en  = 1'b1;
					end
					4'hE: begin
						alu_op = SHL;
						vf_en  = 1'b1;
					end
					default: begin
						wb_en       = 1'b0;
						unsupported = 1'b1;
					end
				endcase
			end
			4'h9: begin
				if (op[3:0] == 4'h0) begin
					skip   = NE;
					pc_sel = SKIP;
				end else begin
					unsupported = 1'b1;
				end
			end
			4'hB: begin
				// V0 supplies the jump offset through read port a
				rd_a   = 4'h0;
				pc_sel = JUMP_V0;
			end
			4'hF: begin
				if (op[7:0] == 8'h07) begin
					wb_en        = 1'b1;
					wb_src_timer = 1'b1;
				end else if (op[7:0] == 8'h15) begin
					dt_we = 1'b1;
				end else begin
					unsupported = 1'b1;
				end
			end
			default: unsupported = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/chip8_alu.sv
// Eight-bit ALU with VF flag result and skip compare
`timescale 1ns/1ps
`default_nettype none

module chip8_alu import chip8_pkg::*; (
	input  byte_t   a,
	input  byte_t   b,
	input  alu_op_t op,
	input  skip_t   skip,
	output byte_t   result,
	output logic    flag,
	output logic    skip_taken
);

	// Nine-bit sum keeps the carry out
	logic [8:0] sum;

	assign sum = {1'b0, a} + {1'b0, b};

	always_comb begin
		result = b;
		flag   = 1'b0;
		case (op)
			PASS_B: result = b;
			OR:     result = a | b;
			AND:    result = a & b;
			XOR:    result = a ^ b;
			ADD: begin
				result = sum[7:0];
				flag   = sum[8];
			end
			SUB: begin
				// Not-borrow is set only when Vx is strictly larger
				result = a - b;
				flag   = (a > b);
			end
			SUBN: begin
				result = b - a;
				flag   = (b > a);
			end
			// Shifts act on Vx only, flag is the bit shifted out
			SHR: begin
				result = {1'b0, a[7:1]};
				flag   = a[0];
			end
			SHL: begin
				result = {a[6:0], 1'b0};
				flag   = a[7];
			end
			default: result = b;
		endcase
	end

	always_comb begin
		case (skip)
			EQ:      skip_taken = (a == b);
			NE:      skip_taken = (a != b);
			default: skip_taken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: verilog/chip8_regfile.sv
// V0 to VF register file, two read ports, one write port and a VF flag write
`timescale 1ns/1ps
`default_nettype none

module chip8_regfile import chip8_pkg::*; (
	input  logic     cpu_clk,
	input  logic     rst,
	input  reg_idx_t rd_a,
	input  reg_idx_t rd_b,
	input  logic     we,
	input  reg_idx_t wr_idx,
	input  byte_t    wr_data,
	input  logic     flag_we,
	input  byte_t    flag_data,
	output byte_t    a_data,
	output byte_t    b_data
);

	byte_t v [16];

	// Reads are combinational, settled during READ
	assign a_data = v[rd_a];
	assign b_data = v[rd_b];

	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			for (int i = 0; i < 16; i++) begin
				v[i] <= '0;
			end
		end else begin
			if (we) begin
				v[wr_idx] <= wr_data;
			end
			// Later assignment wins when Vx is VF
			if (flag_we) begin
				v[FLAG_REG] <= flag_data;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/chip8_pc_unit.sv
// Program counter with next, skip and jump selection
`timescale 1ns/1ps
`default_nettype none

module chip8_pc_unit import chip8_pkg::*; (
	input  logic    cpu_clk,
	input  logic    rst,
	input  logic    en,
	input  pc_sel_t sel,
	input  logic    skip_taken,
	input  addr_t   target,
	input  byte_t   v0,
	output addr_t   pc
);

	addr_t pc_next;

	always_comb begin
		case (sel)
			// A taken skip steps over one whole opcode
			SKIP:    pc_next = skip_taken ? pc + (INSTR_BYTES << 1) : pc + INSTR_BYTES;
			JUMP:    pc_next = target;
			// Wraps at 12 bits
			JUMP_V0: pc_next = target + addr_t'(v0);
			default: pc_next = pc + INSTR_BYTES;
		endcase
	end

	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			pc <= PROGRAM_START;
		end else if (en) begin
			pc <= pc_next;
		end
	end

endmodule

`default_nettype wire

// File: verilog/chip8_delay_timer.sv
// Delay timer byte with its own tick prescaler
`timescale 1ns/1ps
`default_nettype none

module chip8_delay_timer import chip8_pkg::*; #(
	parameter int TICK_DIV = 4
) (
	input  logic  cpu_clk,
	input  logic  rst,
	input  logic  we,
	input  byte_t wdata,
	output byte_t value
);

	// At least one bit so TICK_DIV of 1 still builds
	localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

	logic [CNT_W-1:0] div_cnt;
	logic             tick;

	assign tick = (div_cnt == CNT_W'(TICK_DIV - 1));

	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			div_cnt <= '0;
			value   <= '0;
		end else if (we) begin
			// Fresh load gets a full prescaler period
			div_cnt <= '0;
			value   <= wdata;
		end else begin
			div_cnt <= tick ? '0 : div_cnt + 1'b1;
			// Stops at zero
			if (tick && value != 8'd0) begin
				value <= value - 8'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/chip8_exec_fsm.sv
// Instruction sequencer FSM with busy level and retire strobe
`timescale 1ns/1ps
`default_nettype none

module chip8_exec_fsm import chip8_pkg::*; (
	input  logic cpu_clk,
	input  logic rst,
	input  logic instr_valid,
	output logic busy,
	output logic exec_en,
	output logic retire
);

	exec_state_t state;

	// Busy from the accepting edge until the retire cycle
	assign busy    = (state != IDLE);
	assign exec_en = (state == EXEC);

	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			state  <= IDLE;
			retire <= 1'b0;
		end else begin
			// One-cycle strobe right after the EXEC edge
			retire <= (state == EXEC);
			case (state)
				IDLE: begin
					// Strobes while busy never reach this branch
					if (instr_valid) begin
						state <= READ;
					end
				end
				// Register reads settle here
				READ: state <= EXEC;
				// Register file, PC and timer commit at this edge
				EXEC: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/chip8_core.sv
// CHIP-8 execute core top level with trace port
`timescale 1ns/1ps
`default_nettype none

module chip8_core import chip8_pkg::*; #(
	parameter int TICK_DIV = 4
) (
	input  logic     cpu_clk,
	input  logic     rst,
	input  logic     instr_valid,
	input  opcode_t  instr,
	output logic     busy,
	output logic     retire,
	output addr_t    pc,
	output logic     wb_en,
	output reg_idx_t wb_idx,
	output byte_t    wb_data,
	output logic     vf_en,
	output byte_t    vf_data,
	output logic     unsupported
);

	opcode_t  op_q;
	logic     exec_en;
	reg_idx_t rd_a;
	reg_idx_t rd_b;
	alu_op_t  alu_op;
	logic     use_imm;
	byte_t    imm;
	skip_t    skip;
	pc_sel_t  pc_sel;
	addr_t    target;
	logic     dec_wb_en;
	logic     dec_wb_src_timer;
	logic     dec_vf_en;
	logic     dec_dt_we;
	logic     dec_unsupported;
	byte_t    a_data;
	byte_t    b_data;
	byte_t    alu_b;
	byte_t    alu_result;
	logic     alu_flag;
	logic     skip_taken;
	byte_t    dt_value;
	byte_t    wr_data;
	byte_t    flag_data;

	// Follows the input while idle, so it holds the accepted opcode once busy
	always_ff @(posedge cpu_clk) begin
		if (!busy) begin
			op_q <= instr;
		end
	end

	chip8_exec_fsm u_fsm (
		.cpu_clk     (cpu_clk),
		.rst         (rst),
		.instr_valid (instr_valid),
		.busy        (busy),
		.exec_en     (exec_en),
		.retire      (retire)
	);

	chip8_decoder u_dec (
		.op           (op_q),
		.rd_a         (rd_a),
		.rd_b         (rd_b),
		.alu_op       (alu_op),
		.use_imm      (use_imm),
		.imm          (imm),
		.skip         (skip),
		.pc_sel       (pc_sel),
		.target       (target),
		.wb_en        (dec_wb_en),
		.wb_src_timer (dec_wb_src_timer),
		.vf_en        (dec_vf_en),
		.dt_we        (dec_dt_we),
		.unsupported  (dec_unsupported)
	);

	// kk for immediate forms, Vy otherwise
	assign alu_b     = use_imm ? imm : b_data;
	assign wr_data   = dec_wb_src_timer ? dt_value : alu_result;
	assign flag_data = {7'd0, alu_flag};

	chip8_alu u_alu (
		.a          (a_data),
		.b          (alu_b),
		.op         (alu_op),
		.skip       (skip),
		.result     (alu_result),
		.flag       (alu_flag),
		.skip_taken (skip_taken)
	);

	// Vx is always the destination, from read port a
	chip8_regfile u_regs (
		.cpu_clk   (cpu_clk),
		.rst       (rst),
		.rd_a      (rd_a),
		.rd_b      (rd_b),
		.we        (exec_en & dec_wb_en),
		.wr_idx    (rd_a),
		.wr_data   (wr_data),
		.flag_we   (exec_en & dec_vf_en),
		.flag_data (flag_data),
		.a_data    (a_data),
		.b_data    (b_data)
	);

	// Port a carries V0 for Bnnn; the PC register itself is the trace pc
	chip8_pc_unit u_pc (
		.cpu_clk    (cpu_clk),
		.rst        (rst),
		.en         (exec_en),
		.sel        (pc_sel),
		.skip_taken (skip_taken),
		.target     (target),
		.v0         (a_data),
		.pc         (pc)
	);

	chip8_delay_timer #(
		.TICK_DIV (TICK_DIV)
	) u_dt (
		.cpu_clk (cpu_clk),
		.rst     (rst),
		.we      (exec_en & dec_dt_we),
		.wdata   (a_data),
		.value   (dt_value)
	);

	// Trace flags, held until the next retire
	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			wb_en       <= 1'b0;
			vf_en       <= 1'b0;
			unsupported <= 1'b0;
		end else if (exec_en) begin
			wb_en       <= dec_wb_en;
			vf_en       <= dec_vf_en;
			unsupported <= dec_unsupported;
		end
	end

	// Trace payload
	always_ff @(posedge cpu_clk) begin
		if (exec_en) begin
			wb_idx  <= rd_a;
			wb_data <= wr_data;
			vf_data <= flag_data;
		end
	end

endmodule

`default_nettype wire

// File: tb/chip8_core_tb.sv
// Table-driven testbench for the CHIP-8 execute core with compare tasks and watchdog
`timescale 1ns/1ps
`default_nettype none

module chip8_core_tb import chip8_pkg::*; ();

	localparam int TIMER_POLLS = 24;
	// Value loaded into the delay timer
	localparam byte_t DT_LOAD = 8'd12;
	// 8xyk low nibbles exercised on random operands
	localparam logic [35:0] ALU_SEL = 36'h01234567E;

	typedef struct packed {
		opcode_t  op;
		logic     extra;
		addr_t    pc;
		logic     wb_en;
		reg_idx_t wb_idx;
		byte_t    wb_data;
		logic     vf_en;
		byte_t    vf_data;
		logic     unsup;
	} row_t;

	logic     cpu_clk;
	logic     rst;
	logic     instr_valid;
	opcode_t  instr;
	logic     busy;
	logic     retire;
	addr_t    pc;
	logic     wb_en;
	reg_idx_t wb_idx;
	byte_t    wb_data;
	logic     vf_en;
	byte_t    vf_data;
	logic     unsupported;

	row_t  rows [$];
	// Expected V registers and PC while the table is built
	byte_t vm [16];
	addr_t pm;
	int    errors;
	int    n_pass;
	int    n_fail;

	chip8_core #(
		.TICK_DIV (4)
	) dut (
		.cpu_clk     (cpu_clk),
		.rst         (rst),
		.instr_valid (instr_valid),
		.instr       (instr),
		.busy        (busy),
		.retire      (retire),
		.pc          (pc),
		.wb_en       (wb_en),
		.wb_idx      (wb_idx),
		.wb_data     (wb_data),
		.vf_en       (vf_en),
		.vf_data     (vf_data),
		.unsupported (unsupported)
	);

	always #4 cpu_clk = ~cpu_clk;

	task automatic check_byte(input string name, input byte_t got, input byte_t exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	// Appends one row with expected values from the instruction rules
	task automatic add_row(input opcode_t op, input logic extra);
		row_t       r;
		byte_t      x;
		byte_t      y;
		byte_t      kk;
		logic [8:0] sum;
		addr_t      nxt;
		x   = vm[op[11:8]];
		y   = vm[op[7:4]];
		kk  = op[7:0];
		sum = {1'b0, x} + {1'b0, y};
		nxt = pm + 12'd2;
		r          = '0;
		r.op       = op;
		r.extra    = extra;
		r.wb_idx   = op[11:8];
		case (op[15:12])
			4'h1: nxt = op[11:0];
			4'h3: nxt = (x == kk) ? pm + 12'd4 : nxt;
			4'h4: nxt = (x != kk) ? pm + 12'd4 : nxt;
			4'h5: begin
				r.unsup = (op[3:0] != 4'h0);
				nxt     = (!r.unsup && x == y) ? pm + 12'd4 : nxt;
			end
			4'h9: begin
				r.unsup = (op[3:0] != 4'h0);
				nxt     = (!r.unsup && x != y) ? pm + 12'd4 : nxt;
			end
			4'h6: begin
				r.wb_en   = 1'b1;
				r.wb_data = kk;
			end
			4'h7: begin
				r.wb_en   = 1'b1;
				r.wb_data = x + kk;
			end
			4'h8: begin
				r.wb_en = 1'b1;
				r.vf_en = 1'b1;
				case (op[3:0])
					4'h0: {r.vf_en, r.wb_data} = {1'b0, y};
					4'h1: {r.vf_en, r.wb_data} = {1'b0, x | y};
					4'h2: {r.vf_en, r.wb_data} = {1'b0, x & y};
					4'h3: {r.vf_en, r.wb_data} = {1'b0, x ^ y};
					4'h4: {r.vf_data[0], r.wb_data} = sum;
					4'h5: {r.vf_data[0], r.wb_data} = {x > y, x - y};
					4'h6: {r.vf_data[0], r.wb_data} = {x[0], x >> 1};
					4'h7: {r.vf_data[0], r.wb_data} = {y > x, y - x};
					4'hE: {r.vf_data[0], r.wb_data} = {x[7], x << 1};
					default: {r.unsup, r.wb_en, r.vf_en} = 3'b100;
				endcase
			end
			4'hB: nxt = op[11:0] + {4'h0, vm[0]};
			// Fx15 only loads the timer
			4'hF: r.unsup = (op[7:0] != 8'h15);
			default: r.unsup = 1'b1;
		endcase
		r.pc = nxt;
		pm   = nxt;
		if (r.wb_en) begin
			vm[op[11:8]] = r.wb_data;
		end
		// Flag write lands after Vx
		if (r.vf_en) begin
			vm[FLAG_REG] = r.vf_data;
		end
		rows.push_back(r);
	endtask

	// Strobes one opcode and waits for retire with an optional second strobe while busy
	task automatic issue_instr(input opcode_t op, input logic extra, output logic ok);
		int n;
		n  = 0;
		ok = 1'b0;
		@(posedge cpu_clk);
		instr_valid <= 1'b1;
		instr       <= op;
		while (!ok && n < 6) begin
			@(posedge cpu_clk);
			n++;
			if (n == 1 && extra) begin
				// Add to V6 that must never execute
				instr <= 16'h7601;
			end else begin
				instr_valid <= 1'b0;
			end
			@(negedge cpu_clk);
			if (n < 3) begin
				check_bit("busy", busy, 1'b1);
			end
			ok = retire;
		end
		if (!ok || n != 3) begin
			$display("Opcode %h did not retire three cycles after its strobe", op);
			errors++;
		end
	endtask

	task automatic check_row(input row_t r);
		check_addr("pc", pc, r.pc);
		check_bit("unsupported", unsupported, r.unsup);
		check_bit("wb_en", wb_en, r.wb_en);
		check_bit("vf_en", vf_en, r.vf_en);
		if (r.wb_en) begin
			check_idx("wb_idx", wb_idx, r.wb_idx);
			check_byte("wb_data", wb_data, r.wb_data);
		end
		if (r.vf_en) begin
			check_byte("vf_data", vf_data, r.vf_data);
		end
	endtask

	task automatic count_test(input string name, input int e0);
		if (errors == e0) begin
			n_pass++;
		end else begin
			n_fail++;
		end
		$display("Test %s: %s", name, (errors == e0) ? "ok" : "failed");
	endtask

	// Run limit scales with the number of instructions
	initial begin
		#1;
		#((rows.size() + TIMER_POLLS) * 10 * 8);
		$display("Watchdog expired before the tests finished");
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		int    e0;
		int    zeros;
		logic  ok;
		byte_t prev;
		cpu_clk     = 1'b0;
		rst         = 1'b1;
		instr_valid = 1'b0;
		instr       = '0;
		errors      = 0;
		n_pass      = 0;
		n_fail      = 0;
		void'($urandom(32'h538));
		pm          = PROGRAM_START;
		foreach (vm[i]) begin
			vm[i] = 8'd0;
		end

		// Arithmetic group on fresh random operands in V1 and V2
		for (int i = 0; i < 9; i++) begin
			add_row({8'h61, 8'($urandom)}, 1'b0);
			add_row({8'h62, 8'($urandom)}, 1'b0);
			add_row({12'h812, ALU_SEL[i*4 +: 4]}, 1'b0);
		end
		// Forced carry and then equal operands for a clear not-borrow
		add_row(16'h61FF, 1'b0);
		add_row(16'h6201, 1'b0);
		add_row(16'h8124, 1'b0);
		add_row(16'h6177, 1'b0);
		add_row(16'h6277, 1'b0);
		add_row(16'h8125, 1'b0);
		// Add byte wraps without a flag
		add_row({8'h63, 8'($urandom)}, 1'b0);
		add_row({8'h73, 8'($urandom)}, 1'b0);
		add_row(16'h73FF, 1'b0);
		// Skips both taken and not taken
		add_row(16'h6455, 1'b0);
		add_row(16'h3455, 1'b0);
		add_row(16'h3456, 1'b0);
		add_row(16'h4455, 1'b0);
		add_row(16'h4456, 1'b0);
		add_row(16'h6555, 1'b0);
		add_row(16'h5450, 1'b0);
		add_row(16'h9450, 1'b0);
		add_row(16'h6556, 1'b0);
		add_row(16'h5450, 1'b0);
		add_row(16'h9450, 1'b0);
		add_row(16'h5451, 1'b0);
		// Jumps where Bnnn wraps past 0xFFF
		add_row(16'h13A4, 1'b0);
		add_row(16'h60F0, 1'b0);
		add_row(16'hBF80, 1'b0);
		// Unsupported opcodes
		add_row(16'h00E0, 1'b0);
		add_row(16'hE19E, 1'b0);
		add_row(16'hF133, 1'b0);
		add_row(16'h8128, 1'b0);
		// Second strobe while busy leaves V6 at 42
		add_row(16'h6642, 1'b1);
		add_row(16'h7600, 1'b0);
		add_row({8'h67, DT_LOAD}, 1'b0);
		add_row(16'hF715, 1'b0);

		repeat (4) @(posedge cpu_clk);
		rst <= 1'b0;
		@(negedge cpu_clk);
		e0 = errors;
		check_bit("busy", busy, 1'b0);
		check_bit("retire", retire, 1'b0);
		check_addr("pc", pc, PROGRAM_START);
		check_bit("wb_en", wb_en, 1'b0);
		check_bit("vf_en", vf_en, 1'b0);
		check_bit("unsupported", unsupported, 1'b0);
		count_test("reset", e0);

		foreach (rows[i]) begin
			e0 = errors;
			issue_instr(rows[i].op, rows[i].extra, ok);
			if (ok) begin
				check_row(rows[i]);
			end
			if (rows[i].extra) begin
				repeat (4) begin
					@(negedge cpu_clk);
					check_bit("retire", retire, 1'b0);
				end
			end
			count_test($sformatf("%0d op %h", i, rows[i].op), e0);
		end

		// Timer reads fall monotonically to zero and stay there
		prev  = DT_LOAD;
		zeros = 0;
		for (int i = 0; i < TIMER_POLLS && zeros < 4; i++) begin
			e0 = errors;
			issue_instr(16'hF807, 1'b0, ok);
			pm = pm + 12'd2;
			if (ok) begin
				check_addr("pc", pc, pm);
				check_bit("unsupported", unsupported, 1'b0);
				check_bit("vf_en", vf_en, 1'b0);
				check_bit("wb_en", wb_en, 1'b1);
				check_idx("wb_idx", wb_idx, 4'h8);
				if (i == 0 && wb_data < DT_LOAD - 8'd1) begin
					$display("First timer read %0d is below the loaded value minus one", wb_data);
					errors++;
				end
				if (wb_data > prev) begin
					$display("Timer rose from %0d to %0d", prev, wb_data);
					errors++;
				end
				prev  = wb_data;
				zeros = (wb_data == 8'd0) ? zeros + 1 : 0;
			end
			count_test($sformatf("timer poll %0d", i), e0);
		end
		if (zeros < 4) begin
			$display("Delay timer never settled at zero");
			errors++;
			n_fail++;
		end

		$display("%0d tests passed, %0d tests failed", n_pass, n_fail);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: vlog.f
verilog/chip8_pkg.sv
verilog/chip8_decoder.sv
verilog/chip8_alu.sv
verilog/chip8_regfile.sv
verilog/chip8_pc_unit.sv
verilog/chip8_delay_timer.sv
verilog/chip8_exec_fsm.sv
verilog/chip8_core.sv
tb/chip8_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the CHIP-8 core testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module chip8_core_tb \
	--Mdir obj_dir -o chip8_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/chip8_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "STATUS: FAIL" sim.log; then
	exit 1
fi
exit 0
